//--- src/frame_link_pkg.sv
package frame_link_pkg;

   // ##############################
   // word format
   // ##############################

   localparam int word_w = 32;          // one link word

   // header fields, tag in the high half
   typedef struct packed {
      logic [15:0] tag;                 // frame tag, passed through untouched
      logic [15:0] len;                 // payload words after the header
   } frame_hdr_t;

   // the same word seen two ways
   // raw for payload, hdr when it opens a frame
   typedef union packed {
      logic [word_w-1:0] raw;           // plain payload data
      frame_hdr_t        hdr;           // header view
   } frame_word_u;

   // ##############################
   // reader states
   // ##############################

   // st_idle    nothing in flight, no frame open
   // st_header  header word lands this cycle
   // st_payload payload words still to come
   typedef enum logic [1:0] {
      st_idle    = 2'd0,
      st_header  = 2'd1,
      st_payload = 2'd2
   } rd_state_e;

endpackage

//--- src/fifo_rd_if.sv
interface fifo_rd_if;
   import frame_link_pkg::*;

   logic              pop;              // read one word
   logic              empty;            // no word available
   logic [word_w-1:0] dout;             // data from the fifo memory
   logic              dvalid;           // dout valid, one cycle after pop

   // fifo side
   modport fifo (
      input  pop,
      output empty,
      output dout,
      output dvalid
   );

   // frame reader side
   // pop only while empty is low
   modport reader (
      output pop,
      input  empty,
      input  dout,
      input  dvalid
   );

endinterface

//--- src/dp_memory.sv
module dp_memory #(
   parameter int DEPTH = 16
) (
   // write port
   input  logic                              wr_clk,
   input  logic                              wr_en,
   input  logic [$clog2(DEPTH)-1:0]          wr_addr,
   input  logic [frame_link_pkg::word_w-1:0] wr_din,
   // read port
   input  logic                              rd_clk,
   input  logic                              rd_en,
   input  logic [$clog2(DEPTH)-1:0]          rd_addr,
   output logic [frame_link_pkg::word_w-1:0] rd_dout
);
   import frame_link_pkg::*;

   // ##############################
   // storage
   // ##############################

   logic [word_w-1:0] mem [DEPTH];      // one entry per fifo slot

   // write in the producer domain
   always_ff @(posedge wr_clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_din;
      end
   end

   // registered read in the consumer domain
   // data shows up one rd_clk after rd_en
   always_ff @(posedge rd_clk)
   begin
      if (rd_en)
      begin
         rd_dout <= mem[rd_addr];       // holds value when idle
      end
   end

endmodule

//--- src/fifo_async.sv
module fifo_async #(
   parameter int DEPTH = 16
) (
   input  logic                              nreset,      // async, active low
   // write side
   input  logic                              wr_clk,
   input  logic                              wr_en,
   input  logic [frame_link_pkg::word_w-1:0] wr_din,
   output logic                              wr_credit,   // one pulse per freed slot
   // read side
   input  logic                              rd_clk,
   fifo_rd_if.fifo                           rd,
   // memory beside the fifo
   output logic                              mem_wr_en,
   output logic [$clog2(DEPTH)-1:0]          mem_wr_addr,
   output logic [frame_link_pkg::word_w-1:0] mem_wr_din,
   output logic                              mem_rd_en,
   output logic [$clog2(DEPTH)-1:0]          mem_rd_addr,
   input  logic [frame_link_pkg::word_w-1:0] mem_rd_dout
);

   localparam int aw = $clog2(DEPTH);   // address bits, pointers get one more

   // gray to binary, msb passes through
   function automatic logic [aw:0] gray2bin(input logic [aw:0] g);
      logic [aw:0] b;
      b[aw] = g[aw];
      for (int i = aw - 1; i >= 0; i--)
      begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // ##############################
   // write domain
   // ##############################

   logic [aw:0] wr_bin, wr_bin_nxt;
   logic [aw:0] wr_gray;
   logic [aw:0] rd_gray;                // read pointer, gray, rd_clk domain
   logic [aw:0] rd_gray_s1, rd_gray_s2; // read pointer, synced into wr_clk
   logic [aw:0] rd_bin_w;               // synced read count, binary
   logic [aw:0] released;               // credits handed back so far

   // no full check, the producer only writes with a credit in hand
   assign wr_bin_nxt  = wr_bin + {{aw{1'b0}}, wr_en};
   assign mem_wr_en   = wr_en;
   assign mem_wr_addr = wr_bin[aw-1:0];
   assign mem_wr_din  = wr_din;

   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end
      else
      begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);  // one bit flips per write
      end
   end

   // two flop sync of the read pointer
   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end
      else
      begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   assign rd_bin_w = gray2bin(rd_gray_s2);

   // credit pacer
   // released trails the synced read count, one step per cycle,
   // so a jump of several slots becomes several separate pulses
   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         released  <= '0;
         wr_credit <= 1'b0;
      end
      else if (released != rd_bin_w)
      begin
         released  <= released + 1'b1;
         wr_credit <= 1'b1;
      end
      else
      begin
         wr_credit <= 1'b0;
      end
   end

   // ##############################
   // read domain
   // ##############################

   logic [aw:0] rd_bin, rd_bin_nxt;
   logic [aw:0] rd_gray_nxt;
   logic [aw:0] wr_gray_s1, wr_gray_s2; // write pointer, synced into rd_clk
   logic        pop_ok;                 // pop that actually reads

   assign pop_ok      = rd.pop & ~rd.empty;   // guard a stray pop on empty
   assign rd_bin_nxt  = rd_bin + {{aw{1'b0}}, pop_ok};
   assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);
   assign mem_rd_en   = pop_ok;
   assign mem_rd_addr = rd_bin[aw-1:0];
   assign rd.dout     = mem_rd_dout;          // registered in the memory

   // two flop sync of the write pointer
   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end
      else
      begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   // pointers, empty flag and data strobe
   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_bin    <= '0;
         rd_gray   <= '0;
         rd.empty  <= 1'b1;
         rd.dvalid <= 1'b0;
      end
      else
      begin
         rd_bin    <= rd_bin_nxt;
         rd_gray   <= rd_gray_nxt;
         rd.empty  <= (rd_gray_nxt == wr_gray_s2);  // uses next ptr, no extra pop
         rd.dvalid <= pop_ok;                       // memory data lands next cycle
      end
   end

endmodule

//--- src/credit_counter.sv
module credit_counter #(
   parameter int OUT_CREDITS = 4
) (
   input  logic rd_clk,
   input  logic nreset,
   input  logic take,                   // reader pops a word bound for the output
   input  logic give,                   // consumer hands one credit back
   output logic avail                   // a further pop is allowed
);

   localparam int cw = $clog2(OUT_CREDITS + 1);   // holds 0..OUT_CREDITS

   // ##############################
   // credit count
   // ##############################

   logic [cw-1:0] count;

   // charged at pop time, so a word still in flight from the
   // memory has already spent its credit
   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         count <= cw'(OUT_CREDITS);    // consumer starts with a full window
      end
      else if (take && !give)
      begin
         count <= count - 1'b1;
      end
      else if (give && !take)
      begin
         count <= count + 1'b1;
      end
      // take and give together cancel out
   end

   // count is already net of in-flight words
   // nonzero means room for one more
   assign avail = (count != '0);

endmodule

//--- src/frame_reader.sv
module frame_reader (
   input  logic                              rd_clk,
   input  logic                              nreset,
   fifo_rd_if.reader                         rd,
   input  logic                              avail,       // downstream credit left
   output logic                              take,        // spends one credit
   output logic                              out_valid,
   output logic                              out_sof,
   output logic                              out_eof,
   output logic [frame_link_pkg::word_w-1:0] out_data
);
   import frame_link_pkg::*;

   // ##############################
   // pop control
   // ##############################

   logic pop;

   // pop only with a word waiting and a credit to spend
   assign pop     = ~rd.empty & avail;
   assign rd.pop  = pop;
   assign take    = pop;

   // ##############################
   // word decode
   // ##############################

   frame_word_u word;                   // current fifo output
   rd_state_e   state, state_nxt;
   logic [15:0] remaining;              // payload words still to come
   logic        hdr_zero;               // header with empty payload
   logic        last_pld;               // final payload word of the frame

   assign word     = rd.dout;
   assign hdr_zero = (word.hdr.len == 16'd0);
   assign last_pld = (remaining == 16'd1);

   // outputs come straight off the fifo registers
   assign out_valid = rd.dvalid;
   assign out_data  = word.raw;
   assign out_sof   = rd.dvalid & (state == st_header);
   assign out_eof   = rd.dvalid & (((state == st_header) & hdr_zero) |
                                   ((state == st_payload) & last_pld));

   // ##############################
   // frame FSM
   // ##############################

   // state names the word that lands next on dout.
   // a pop in the cycle that closes a frame brings the next header
   always_comb
   begin
      state_nxt = state;
      case (state)
         st_idle:
         begin
            if (pop)
            begin
               state_nxt = st_header;
            end
         end
         st_header:                     // dvalid is always high here
         begin
            if (!hdr_zero)
            begin
               state_nxt = st_payload;
            end
            else
            begin
               state_nxt = pop ? st_header : st_idle;
            end
         end
         st_payload:
         begin
            if (rd.dvalid && last_pld)
            begin
               state_nxt = pop ? st_header : st_idle;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state     <= st_idle;
         remaining <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (state == st_header)
         begin
            remaining <= word.hdr.len;        // load from the header
         end
         else if (state == st_payload && rd.dvalid)
         begin
            remaining <= remaining - 1'b1;    // one payload word consumed
         end
      end
   end

endmodule

//--- src/cdc_frame_link.sv
module cdc_frame_link #(
   parameter int DEPTH       = 16,      // fifo slots, power of two
   parameter int OUT_CREDITS = 4        // consumer credit window
) (
   input  logic                              nreset,
   // producer, wr_clk domain
   input  logic                              wr_clk,
   input  logic                              wr_valid,
   input  logic [frame_link_pkg::word_w-1:0] wr_data,
   output logic                              wr_credit,
   // consumer, rd_clk domain
   input  logic                              rd_clk,
   input  logic                              out_credit,
   output logic                              out_valid,
   output logic [frame_link_pkg::word_w-1:0] out_data,
   output logic                              out_sof,
   output logic                              out_eof
);
   import frame_link_pkg::*;

   localparam int aw = $clog2(DEPTH);

   // ##############################
   // internal nets
   // ##############################

   logic              mem_wr_en;
   logic [aw-1:0]     mem_wr_addr;
   logic [word_w-1:0] mem_wr_din;
   logic              mem_rd_en;
   logic [aw-1:0]     mem_rd_addr;
   logic [word_w-1:0] mem_rd_dout;
   logic              avail;            // credit counter to reader
   logic              take;             // reader to credit counter

   fifo_rd_if u_rd_if ();               // fifo read side to reader

   // ##############################
   // instances
   // ##############################

   fifo_async #(.DEPTH(DEPTH)) u_fifo_async (
      .nreset      (nreset),
      .wr_clk      (wr_clk),
      .wr_en       (wr_valid),
      .wr_din      (wr_data),
      .wr_credit   (wr_credit),
      .rd_clk      (rd_clk),
      .rd          (u_rd_if.fifo),
      .mem_wr_en   (mem_wr_en),
      .mem_wr_addr (mem_wr_addr),
      .mem_wr_din  (mem_wr_din),
      .mem_rd_en   (mem_rd_en),
      .mem_rd_addr (mem_rd_addr),
      .mem_rd_dout (mem_rd_dout)
   );

   dp_memory #(.DEPTH(DEPTH)) u_dp_memory (
      .wr_clk  (wr_clk),
      .wr_en   (mem_wr_en),
      .wr_addr (mem_wr_addr),
      .wr_din  (mem_wr_din),
      .rd_clk  (rd_clk),
      .rd_en   (mem_rd_en),
      .rd_addr (mem_rd_addr),
      .rd_dout (mem_rd_dout)
   );

   credit_counter #(.OUT_CREDITS(OUT_CREDITS)) u_credit_counter (
      .rd_clk (rd_clk),
      .nreset (nreset),
      .take   (take),
      .give   (out_credit),
      .avail  (avail)
   );

   frame_reader u_frame_reader (
      .rd_clk    (rd_clk),
      .nreset    (nreset),
      .rd        (u_rd_if.reader),
      .avail     (avail),
      .take      (take),
      .out_valid (out_valid),
      .out_sof   (out_sof),
      .out_eof   (out_eof),
      .out_data  (out_data)
   );

endmodule

//--- tb/frame_link_chk.sv
module frame_link_chk (
   input logic                              nreset,
   input logic                              wr_clk,
   input logic                              wr_valid,
   input logic                              wr_credit,
   input logic                              rd_clk,
   input logic                              out_valid,
   input logic                              out_sof,
   input logic                              out_eof,
   input logic [frame_link_pkg::word_w-1:0] out_data
);
   timeunit 1ns;
   timeprecision 1ps;

   // ##############################
   // producer credits
   // ##############################

   int outstanding;                     // words written, credit not yet back
   int credits_back;                    // wr_credit pulses so far
   int words_read;                      // words delivered on the read side

   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         outstanding  <= 0;
         credits_back <= 0;
      end
      else
      begin
         outstanding  <= outstanding + int'(wr_valid) - int'(wr_credit);
         credits_back <= credits_back + int'(wr_credit);
      end
   end

   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         words_read <= 0;
      end
      else if (out_valid)
      begin
         words_read <= words_read + 1;
      end
   end

   // a credit with no word behind it
   a_no_extra_credit: assert property (@(posedge wr_clk) disable iff (!nreset)
      (outstanding + int'(wr_valid) - int'(wr_credit)) >= 0)
      else $error("credit returned for a slot never written");

   // slot freed only after its word left,
   // sync path is several wr_clk edges, longer than one rd_clk
   a_credit_after_read: assert property (@(posedge wr_clk) disable iff (!nreset)
      (credits_back + int'(wr_credit)) <= words_read)
      else $error("credit returned before its word was read");

   // ##############################
   // framing
   // ##############################

   logic frame_open;                    // header seen, eof not yet

   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         frame_open <= 1'b0;
      end
      else if (out_valid)
      begin
         frame_open <= ~out_eof;
      end
   end

   // sof exactly on the first word after a closed frame
   a_sof_opens_frame: assert property (@(posedge rd_clk) disable iff (!nreset)
      out_valid |-> (out_sof == !frame_open))
      else $error("sof does not match the frame boundaries");

   // empty frame is one word, nothing left open behind it
   a_zero_len: assert property (@(posedge rd_clk) disable iff (!nreset)
      (out_valid && out_sof && (out_data[15:0] == 16'd0)) |=> !frame_open)
      else $error("zero length frame left open after its header");

endmodule

bind cdc_frame_link frame_link_chk u_frame_link_chk (
   .nreset    (nreset),
   .wr_clk    (wr_clk),
   .wr_valid  (wr_valid),
   .wr_credit (wr_credit),
   .rd_clk    (rd_clk),
   .out_valid (out_valid),
   .out_sof   (out_sof),
   .out_eof   (out_eof),
   .out_data  (out_data)
);

//--- tb/tb_cdc_frame_link.sv
module tb_cdc_frame_link;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DEPTH       = 16;
   localparam int OUT_CREDITS = 4;
   localparam int N_FRAMES    = 40;
   localparam int HOLD_CYCLES = 150;   // rd_clk cycles with credits withheld
   localparam int STALL_LIMIT = 2000;  // wr_clk cycles without a credit
   localparam int DRAIN_LIMIT = 5000;

   logic        nreset;
   logic        wr_clk;
   logic        wr_valid;
   logic [31:0] wr_data;
   logic        wr_credit;
   logic        rd_clk;
   logic        out_credit;
   logic        out_valid;
   logic [31:0] out_data;
   logic        out_sof;
   logic        out_eof;

   logic [31:0] push_q [$];            // every word written, in order
   logic [33:0] exp_q [$];             // {sof, eof, data}
   logic [15:0] gen_lfsr  = 16'd98;    // frames and producer gaps
   logic [15:0] cons_lfsr = 16'd98;    // consumer credit delays
   int          mismatch_errs = 0;
   int          other_errs    = 0;
   int          written = 0;
   int          credit_total = 0;      // wr_credit pulses seen
   int          rx_count = 0;
   int          returned = 0;          // out_credit pulses driven
   int          owed = 0;
   int          delay = 0;
   int          zero_frames = 0;
   int          zero_seen = 0;
   logic        withhold;

   cdc_frame_link #(.DEPTH(DEPTH), .OUT_CREDITS(OUT_CREDITS)) u_cdc_frame_link (
      .nreset     (nreset),
      .wr_clk     (wr_clk),
      .wr_valid   (wr_valid),
      .wr_data    (wr_data),
      .wr_credit  (wr_credit),
      .rd_clk     (rd_clk),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_sof    (out_sof),
      .out_eof    (out_eof)
   );

   initial
   begin
      wr_clk = 1'b0;
      forever #5 wr_clk = ~wr_clk;
   end

   initial
   begin
      rd_clk = 1'b0;
      forever #7 rd_clk = ~rd_clk;     // unrelated to wr_clk
   end

   // ##############################
   // random source
   // ##############################

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one step per bit, msb first
   task automatic take_bits(inout logic [15:0] st, input int nbits, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < nbits; i++)
      begin
         val = {val[30:0], st[0]};
         st  = lfsr_step(st);
      end
   endtask

   task automatic make_frames();
      logic [31:0] len;
      logic [31:0] tag;
      logic [31:0] val;
      for (int f = 0; f < N_FRAMES; f++)
      begin
         take_bits(gen_lfsr, 3, len);
         if (f % 8 == 2)
         begin
            len = 0;                    // a few forced empty frames
         end
         take_bits(gen_lfsr, 16, tag);
         push_q.push_back({tag[15:0], len[15:0]});   // header, tag high, len low
         for (int p = 0; p < int'(len); p++)
         begin
            take_bits(gen_lfsr, 32, val);
            push_q.push_back(val);
         end
      end
   endtask

   // ##############################
   // reference model
   // ##############################

   function automatic void build_expected();
      int          remaining;
      logic [15:0] len;
      logic        sof;
      logic        eof;
      remaining = 0;
      foreach (push_q[i])
      begin
         if (remaining == 0)
         begin                          // word opens a frame
            len       = push_q[i][15:0];
            sof       = 1'b1;
            eof       = (len == 16'd0);
            remaining = int'(len);
            if (len == 16'd0)
            begin
               zero_frames++;
            end
         end
         else
         begin
            sof = 1'b0;
            eof = (remaining == 1);     // last payload word
            remaining--;
         end
         exp_q.push_back({sof, eof, push_q[i]});
      end
   endfunction

   task automatic compare_word();
      logic [33:0] e;
      if (exp_q.size() == 0)
      begin
         other_errs++;
         $display("out_valid with no word left to expect, data %h", out_data);
      end
      else
      begin
         e = exp_q.pop_front();
         if (out_data !== e[31:0])
         begin
            mismatch_errs++;
            $display("Mismatch out_data: got %h expected %h", out_data, e[31:0]);
         end
         if (out_sof !== e[33])
         begin
            mismatch_errs++;
            $display("Mismatch out_sof: got %h expected %h", out_sof, e[33]);
         end
         if (out_eof !== e[32])
         begin
            mismatch_errs++;
            $display("Mismatch out_eof: got %h expected %h", out_eof, e[32]);
         end
      end
   endtask

   // compare and consumer credit model, outputs stable on the falling edge
   always @(negedge rd_clk)
   begin
      if (out_valid)
      begin
         compare_word();
         rx_count++;
         owed++;
         if (out_sof && out_eof)
         begin
            zero_seen++;
         end
      end
      out_credit = 1'b0;
      if (!withhold && owed > 0)
      begin
         if (delay > 0)
         begin
            delay--;
         end
         else
         begin
            out_credit = 1'b1;          // one credit back
            owed--;
            returned++;
            take_bits(cons_lfsr, 2, delay);
         end
      end
      if (rx_count - returned > OUT_CREDITS)
      begin
         other_errs++;
         $display("consumer received more words than its credit window");
      end
   end

   // ##############################
   // producer
   // ##############################

   task automatic next_wr_cycle();
      @(negedge wr_clk);
      if (wr_credit)
      begin
         credit_total++;
      end
   endtask

   task automatic drive_frames();
      int          idx;
      int          stall;
      logic [31:0] gap;
      logic [31:0] r;
      idx   = 0;
      stall = 0;
      gap   = '0;
      while (idx < push_q.size())
      begin
         next_wr_cycle();
         wr_valid = 1'b0;
         if (gap != 0)
         begin
            gap--;
         end
         else if (written - credit_total < DEPTH)   // credit in hand
         begin
            wr_valid = 1'b1;
            wr_data  = push_q[idx];
            idx++;
            written++;
            stall = 0;
            take_bits(gen_lfsr, 1, r);
            if (r[0])
            begin
               take_bits(gen_lfsr, 2, gap);          // idle 0..3 cycles
            end
         end
         else
         begin
            stall++;
            if (stall > STALL_LIMIT)
            begin
               other_errs++;
               $display("producer waited too long for a credit");
               break;
            end
         end
      end
      next_wr_cycle();
      wr_valid = 1'b0;
   endtask

   // consumer keeps its credits until the window is spent, then lets go
   task automatic hold_and_release();
      int cnt;
      cnt = 0;
      while (rx_count < OUT_CREDITS && cnt < 500)
      begin
         @(posedge rd_clk);
         cnt++;
      end
      if (rx_count < OUT_CREDITS)
      begin
         other_errs++;
         $display("credit window never filled before the hold");
      end
      repeat (HOLD_CYCLES) @(posedge rd_clk);
      if (rx_count > OUT_CREDITS)
      begin
         mismatch_errs++;
         $display("Mismatch rx_count: got %h expected at most %h", rx_count, OUT_CREDITS);
      end
      @(posedge rd_clk);
      withhold = 1'b0;
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
      if (mismatch_errs == 0 && other_errs == 0)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   endtask

   // ##############################
   // main sequence
   // ##############################

   initial
   begin
      int cnt;
      nreset     = 1'b0;
      wr_valid   = 1'b0;
      wr_data    = '0;
      out_credit = 1'b0;
      withhold   = 1'b1;
      make_frames();
      build_expected();
      repeat (4)
      begin
         @(negedge rd_clk);
         if (out_valid !== 1'b0 || out_sof !== 1'b0 || out_eof !== 1'b0 ||
             wr_credit !== 1'b0)
         begin
            other_errs++;
            $display("output active during reset");
         end
      end
      nreset = 1'b1;
      fork
         drive_frames();
         hold_and_release();
      join
      cnt = 0;
      while ((exp_q.size() != 0 || credit_total != written) && cnt < DRAIN_LIMIT)
      begin
         next_wr_cycle();
         cnt++;
      end
      if (cnt >= DRAIN_LIMIT)
      begin
         other_errs++;
         $display("timed out waiting for the link to drain");
      end
      repeat (30) next_wr_cycle();      // catch stray words or credits
      if (exp_q.size() != 0)
      begin
         other_errs++;
         $display("%0d expected words never arrived", exp_q.size());
      end
      if (credit_total != written)
      begin
         mismatch_errs++;
         $display("Mismatch wr_credit pulses: got %h expected %h", credit_total, written);
      end
      if (rx_count != push_q.size())
      begin
         mismatch_errs++;
         $display("Mismatch rx_count: got %h expected %h", rx_count, push_q.size());
      end
      if (zero_seen != zero_frames)
      begin
         mismatch_errs++;
         $display("Mismatch zero_frames: got %h expected %h", zero_seen, zero_frames);
      end
      finish_run();
   end

endmodule

//--- compile.f
src/frame_link_pkg.sv
src/fifo_rd_if.sv
src/dp_memory.sv
src/fifo_async.sv
src/credit_counter.sv
src/frame_reader.sv
src/cdc_frame_link.sv
tb/frame_link_chk.sv
tb/tb_cdc_frame_link.sv

//--- run_sim.sh
#!/bin/sh
# build and run the frame link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_cdc_frame_link \
   -f compile.f \
   --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Some tests failed" sim.log; then
   echo "run_sim: failure reported in sim.log"
   exit 1
fi
echo "run_sim: done"
